// File: rtl/gpio_axi_pkg.sv
package gpio_axi_pkg;

   //####################################################################
   // Slave FSM states
   //####################################################################

   typedef enum logic [1:0] {
      IDLE       = 2'd0,      // Waiting for a request
      WRITE_RESP = 2'd1,      // Holding bvalid until bready
      READ_RESP  = 2'd2       // Holding rvalid until rready
   } axi_state_e;

   //####################################################################
   // Response codes
   //####################################################################

   // Only the two codes this slave can return
   typedef enum logic [1:0] {
      OKAY   = 2'b00,         // Access done
      SLVERR = 2'b10          // Unmapped offset or write to read-only
   } axi_resp_e;

endpackage

// File: rtl/gpio_reg_pkg.sv
package gpio_reg_pkg;

   //####################################################################
   // Register map
   //####################################################################

   localparam int REG_AW = 8;                 // Low address bits decoded

   // Word aligned offsets
   typedef enum logic [REG_AW-1:0] {
      REG_OUT    = 8'h00,     // Output value
      REG_DIR    = 8'h04,     // Output enable per pin
      REG_IN     = 8'h08,     // Synchronized pin state
      REG_OUTSET = 8'h0C,     // Sets output bits
      REG_OUTCLR = 8'h10,     // Clears output bits
      REG_IEN    = 8'h14,     // Interrupt enable per pin
      REG_ILAT   = 8'h18      // Rising edge latch cleared by writing 1
   } gpio_reg_e;

endpackage

// File: rtl/gpio_axi_slave.sv
module gpio_axi_slave
   import gpio_axi_pkg::*;
   import gpio_reg_pkg::*;
(
   input  logic              sys_clk,         // Bus clock
   input  logic              rst_n,           // Async reset, active low
   // Write address and data
   input  logic [REG_AW-1:0] s_axi_awaddr,
   input  logic              s_axi_awvalid,
   output logic              s_axi_awready,
   input  logic [31:0]       s_axi_wdata,
   input  logic              s_axi_wvalid,
   output logic              s_axi_wready,
   // Write response
   output logic              s_axi_bvalid,
   output axi_resp_e         s_axi_bresp,
   input  logic              s_axi_bready,
   // Read address
   input  logic [REG_AW-1:0] s_axi_araddr,
   input  logic              s_axi_arvalid,
   output logic              s_axi_arready,
   // Read data
   output logic              s_axi_rvalid,
   output logic [31:0]       s_axi_rdata,
   output axi_resp_e         s_axi_rresp,
   input  logic              s_axi_rready,
   // Register file side
   output logic              reg_wr,          // One cycle write strobe
   output logic              reg_rd,          // One cycle read strobe
   output logic [REG_AW-1:0] reg_addr,
   output logic [31:0]       reg_wdata,
   input  logic [31:0]       reg_rdata,       // Valid with reg_rd
   input  logic              reg_err          // Valid with either strobe
);

   axi_state_e state;                         // Current FSM state
   axi_state_e state_nxt;
   logic       idle;
   logic       wr_req;
   logic       wr_acc;
   logic       rd_acc;

   assign idle   = (state == IDLE);
   assign wr_req = s_axi_awvalid & s_axi_wvalid;      // Both halves present
   assign wr_acc = idle & wr_req;
   assign rd_acc = idle & ~wr_req & s_axi_arvalid;    // Write wins a tie

   // Ready levels follow the state, low while a response waits
   assign s_axi_awready = idle;
   assign s_axi_wready  = idle;
   assign s_axi_arready = idle & ~wr_req;

   assign s_axi_bvalid = (state == WRITE_RESP);
   assign s_axi_rvalid = (state == READ_RESP);

   assign reg_wr    = wr_acc;                 // Register updates on accept edge
   assign reg_rd    = rd_acc;
   assign reg_addr  = wr_req ? s_axi_awaddr : s_axi_araddr;
   assign reg_wdata = s_axi_wdata;

   //####################################################################
   // FSM
   //####################################################################

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (wr_acc)
               state_nxt = WRITE_RESP;
            else if (rd_acc)
               state_nxt = READ_RESP;
         end
         WRITE_RESP: begin
            if (s_axi_bready)                 // Master took bresp
               state_nxt = IDLE;
         end
         READ_RESP: begin
            if (s_axi_rready)                 // Master took rdata
               state_nxt = IDLE;
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   // Response payload, captured on accept and held under back-pressure
   always_ff @(posedge sys_clk) begin
      if (wr_acc)
         s_axi_bresp <= reg_err ? SLVERR : OKAY;
      if (rd_acc) begin
         s_axi_rdata <= reg_rdata;
         s_axi_rresp <= reg_err ? SLVERR : OKAY;
      end
   end

endmodule

// File: rtl/gpio_regs.sv
module gpio_regs
   import gpio_reg_pkg::*;
#(
   parameter int NGPIO = 24                   // Pin count, 1 to 32
)
(
   input  logic              sys_clk,
   input  logic              rst_n,
   input  logic              reg_wr,          // Write strobe from slave
   input  logic              reg_rd,          // Read strobe from slave
   input  logic [REG_AW-1:0] reg_addr,
   input  logic [31:0]       reg_wdata,
   output logic [31:0]       reg_rdata,
   output logic              reg_err,
   input  logic [NGPIO-1:0]  pin_sync,        // Synchronized pins
   input  logic [NGPIO-1:0]  pin_rise,        // Rising edge pulses
   output logic [NGPIO-1:0]  gpio_out,
   output logic [NGPIO-1:0]  gpio_oe,
   output logic              irq
);

   gpio_reg_e        reg_sel;
   logic [NGPIO-1:0] wdata_n;                 // Write data cut to pin count
   logic [NGPIO-1:0] out_q;                   // REG_OUT
   logic [NGPIO-1:0] dir_q;                   // REG_DIR
   logic [NGPIO-1:0] ien_q;                   // REG_IEN
   logic [NGPIO-1:0] ilat_q;                  // REG_ILAT
   logic [NGPIO-1:0] ilat_clr;
   logic [31:0]      rd_word;
   logic             unmapped;
   logic             bad;

   assign reg_sel = gpio_reg_e'(reg_addr);
   assign wdata_n = reg_wdata[NGPIO-1:0];

   //####################################################################
   // Read decode
   //####################################################################

   always_comb begin
      rd_word  = '0;                          // Bits above NGPIO read 0
      unmapped = 1'b0;
      case (reg_sel)
         REG_OUT:  rd_word[NGPIO-1:0] = out_q;
         REG_DIR:  rd_word[NGPIO-1:0] = dir_q;
         REG_IN:   rd_word[NGPIO-1:0] = pin_sync;
         REG_IEN:  rd_word[NGPIO-1:0] = ien_q;
         REG_ILAT: rd_word[NGPIO-1:0] = ilat_q;
         REG_OUTSET,
         REG_OUTCLR: rd_word = '0;            // Write-only
         default:  unmapped = 1'b1;
      endcase
   end

   assign bad       = unmapped | (reg_wr & (reg_sel == REG_IN));
   assign reg_err   = (reg_wr | reg_rd) & bad;
   assign reg_rdata = reg_rd ? rd_word : 32'd0;

   //####################################################################
   // Write side
   //####################################################################

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_q <= '0;
         dir_q <= '0;
         ien_q <= '0;
      end else if (reg_wr) begin
         case (reg_sel)
            REG_OUT:    out_q <= wdata_n;
            REG_DIR:    dir_q <= wdata_n;
            REG_OUTSET: out_q <= out_q | wdata_n;
            REG_OUTCLR: out_q <= out_q & ~wdata_n;
            REG_IEN:    ien_q <= wdata_n;
            default:    ;                     // IN, ILAT and unmapped
         endcase
      end
   end

   assign ilat_clr = (reg_wr && reg_sel == REG_ILAT) ? wdata_n : '0;

   // New edge beats a clear in the same cycle
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n)
         ilat_q <= '0;
      else
         ilat_q <= (ilat_q & ~ilat_clr) | pin_rise;
   end

   assign gpio_out = out_q;
   assign gpio_oe  = dir_q;
   assign irq      = |(ilat_q & ien_q);       // Enabled latched edges

endmodule

// File: rtl/gpio_pin_sync.sv
module gpio_pin_sync #(
   parameter int NGPIO = 24                   // Pin count
)
(
   input  logic             sys_clk,
   input  logic             rst_n,
   input  logic [NGPIO-1:0] gpio_in,          // Asynchronous pins
   output logic [NGPIO-1:0] pin_sync,         // Second stage output
   output logic [NGPIO-1:0] pin_rise          // One cycle per rising edge
);

   logic [NGPIO-1:0] sync_q1;                 // First stage, may go metastable
   logic [NGPIO-1:0] sync_q2;
   logic [NGPIO-1:0] prev_q;                  // Last cycle's synced value

   //####################################################################
   // Synchronizer and edge detect
   //####################################################################

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         prev_q  <= '0;
      end else begin
         sync_q1 <= gpio_in;
         sync_q2 <= sync_q1;
         prev_q  <= sync_q2;
      end
   end

   assign pin_sync = sync_q2;
   assign pin_rise = sync_q2 & ~prev_q;       // High now, low before

endmodule

// File: rtl/gpio_top.sv
module gpio_top
   import gpio_axi_pkg::*;
   import gpio_reg_pkg::*;
#(
   parameter int NGPIO = 24                   // Number of pins
)
(
   input  logic              sys_clk,         // System clock for bus and pins
   input  logic              rst_n,           // Async reset, active low
   // Pins
   input  logic [NGPIO-1:0]  gpio_in,
   output logic [NGPIO-1:0]  gpio_out,
   output logic [NGPIO-1:0]  gpio_oe,         // 1 drives the pin
   output logic              gpio_irq,
   // AXI4-lite slave
   input  logic [REG_AW-1:0] s_axi_awaddr,
   input  logic              s_axi_awvalid,
   output logic              s_axi_awready,
   input  logic [31:0]       s_axi_wdata,
   input  logic              s_axi_wvalid,
   output logic              s_axi_wready,
   output logic              s_axi_bvalid,
   output axi_resp_e         s_axi_bresp,
   input  logic              s_axi_bready,
   input  logic [REG_AW-1:0] s_axi_araddr,
   input  logic              s_axi_arvalid,
   output logic              s_axi_arready,
   output logic              s_axi_rvalid,
   output logic [31:0]       s_axi_rdata,
   output axi_resp_e         s_axi_rresp,
   input  logic              s_axi_rready
);

   logic              reg_wr;                 // Slave to register file
   logic              reg_rd;
   logic [REG_AW-1:0] reg_addr;
   logic [31:0]       reg_wdata;
   logic [31:0]       reg_rdata;              // Register file to slave
   logic              reg_err;
   logic [NGPIO-1:0]  pin_sync;               // Pin front end to registers
   logic [NGPIO-1:0]  pin_rise;

   // Port names match the wires above
   gpio_axi_slave u_slave (.*);

   gpio_regs #(.NGPIO(NGPIO)) u_regs (
      .*,
      .irq (gpio_irq)
   );

   gpio_pin_sync #(.NGPIO(NGPIO)) u_pins (.*);

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
   output logic sys_clk                       // 40 ns period
);
   timeunit 1ns;
   timeprecision 1ps;

   initial sys_clk = 1'b0;

   always #20 sys_clk = ~sys_clk;             // Half period

endmodule

// File: sim/tb_gpio.sv
module tb_gpio
   import gpio_axi_pkg::*;
   import gpio_reg_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NGPIO    = 24;
   localparam int HS_LIMIT = 20;              // Handshake wait limit in cycles

   typedef enum {OP_WR, OP_RD, OP_PIN} op_e;

   typedef struct {
      string             name;
      op_e               op;
      logic [REG_AW-1:0] addr;
      logic [31:0]       wdata;
      logic [NGPIO-1:0]  pin;
      logic [31:0]       exp_rdata;
      axi_resp_e         exp_resp;
      int                bp;                  // Cycles bready or rready held low
      logic [NGPIO-1:0]  exp_out;             // Pin outputs after the entry
      logic [NGPIO-1:0]  exp_oe;
      logic              exp_irq;
   } entry_t;

   logic              sys_clk;
   logic              rst_n;
   logic [NGPIO-1:0]  gpio_in, gpio_out, gpio_oe;
   logic              gpio_irq;
   logic [REG_AW-1:0] s_axi_awaddr, s_axi_araddr;
   logic [31:0]       s_axi_wdata, s_axi_rdata;
   logic              s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
   logic              s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
   logic              s_axi_rvalid, s_axi_rready;
   axi_resp_e         s_axi_bresp, s_axi_rresp;

   entry_t            tbl[$];                 // Stimulus and expected values
   logic [NGPIO-1:0]  m_out, m_oe;            // Expected pin outputs while building
   logic              m_irq;
   int                errors = 0;
   bit                table_ready = 1'b0;

   tb_clock_gen u_clk (.sys_clk(sys_clk));

   gpio_top #(.NGPIO(NGPIO)) uut (.*);

   //####################################################################
   // Table
   //####################################################################

   function automatic void add_entry(string name, op_e op, logic [REG_AW-1:0] addr,
         logic [31:0] wdata, logic [NGPIO-1:0] pin, logic [31:0] exp_rdata,
         axi_resp_e exp_resp, int bp);
      entry_t e;
      e = '{name, op, addr, wdata, pin, exp_rdata, exp_resp, bp, m_out, m_oe, m_irq};
      tbl.push_back(e);
   endfunction

   function automatic void build_table(logic [31:0] r0, logic [31:0] r1);
      logic [NGPIO-1:0] pins;
      m_out = r0[NGPIO-1:0];                  // Upper byte dropped
      m_oe  = '0;
      m_irq = 1'b0;
      add_entry("out_wr", OP_WR, REG_OUT, r0, '0, '0, OKAY, 0);
      add_entry("out_rd", OP_RD, REG_OUT, '0, '0, 32'(m_out), OKAY, 0);
      m_oe = 24'hC33C5A;
      add_entry("dir_wr", OP_WR, REG_DIR, 32'hA5C3_3C5A, '0, '0, OKAY, 0);
      add_entry("dir_rd", OP_RD, REG_DIR, '0, '0, 32'(m_oe), OKAY, 0);
      m_out = m_out | 24'h0000F0;
      add_entry("set_wr", OP_WR, REG_OUTSET, 32'h0000_00F0, '0, '0, OKAY, 0);
      add_entry("set_rd", OP_RD, REG_OUTSET, '0, '0, 32'h0, OKAY, 0);    // Write-only
      add_entry("out_set_rd", OP_RD, REG_OUT, '0, '0, 32'(m_out), OKAY, 0);
      m_out = m_out & ~24'hFF000F;
      add_entry("clr_wr", OP_WR, REG_OUTCLR, 32'h00FF_000F, '0, '0, OKAY, 0);
      add_entry("clr_rd", OP_RD, REG_OUTCLR, '0, '0, 32'h0, OKAY, 0);
      add_entry("out_clr_rd", OP_RD, REG_OUT, '0, '0, 32'(m_out), OKAY, 0);
      pins = 24'h5A0031;
      add_entry("pin_drive", OP_PIN, '0, '0, pins, '0, OKAY, 0);
      add_entry("in_rd", OP_RD, REG_IN, '0, '0, 32'(pins), OKAY, 0);
      // Every high pin rose from 0 with nothing enabled yet
      add_entry("ilat_noien_rd", OP_RD, REG_ILAT, '0, '0, 32'(pins), OKAY, 0);
      add_entry("ilat_clr_all", OP_WR, REG_ILAT, 32'hFFFF_FFFF, '0, '0, OKAY, 0);
      add_entry("ilat_zero_rd", OP_RD, REG_ILAT, '0, '0, 32'h0, OKAY, 0);
      add_entry("ien_wr", OP_WR, REG_IEN, 32'h0000_0100, '0, '0, OKAY, 0);
      add_entry("ien_rd", OP_RD, REG_IEN, '0, '0, 32'h100, OKAY, 0);
      pins  = pins | 24'h000300;              // Pins 8 and 9 rise but only 8 is enabled
      m_irq = 1'b1;
      add_entry("pin_rise", OP_PIN, '0, '0, pins, '0, OKAY, 0);
      add_entry("ilat_rd", OP_RD, REG_ILAT, '0, '0, 32'h300, OKAY, 0);
      m_irq = 1'b0;
      add_entry("ilat_clr8", OP_WR, REG_ILAT, 32'h0000_0100, '0, '0, OKAY, 0);
      add_entry("ilat_left_rd", OP_RD, REG_ILAT, '0, '0, 32'h200, OKAY, 0);
      add_entry("bad_rd_1c", OP_RD, 8'h1C, '0, '0, 32'h0, SLVERR, 0);
      add_entry("bad_wr_40", OP_WR, 8'h40, 32'hFFFF_FFFF, '0, '0, SLVERR, 0);
      add_entry("in_wr", OP_WR, REG_IN, 32'hFFFF_FFFF, '0, '0, SLVERR, 0);
      add_entry("out_kept_rd", OP_RD, REG_OUT, '0, '0, 32'(m_out), OKAY, 0);
      add_entry("ien_kept_rd", OP_RD, REG_IEN, '0, '0, 32'h100, OKAY, 0);
      add_entry("ilat_kept_rd", OP_RD, REG_ILAT, '0, '0, 32'h200, OKAY, 0);
      m_out = r1[NGPIO-1:0];
      add_entry("bp_wr", OP_WR, REG_OUT, r1, '0, '0, OKAY, 5);
      add_entry("bp_rd", OP_RD, REG_OUT, '0, '0, 32'(m_out), OKAY, 6);
      add_entry("bp_bad_rd", OP_RD, 8'h40, '0, '0, 32'h0, SLVERR, 4);
      add_entry("dir_kept_rd", OP_RD, REG_DIR, '0, '0, 32'(m_oe), OKAY, 0);
   endfunction

   //####################################################################
   // Bus driver
   //####################################################################

   task automatic write_bus(input logic [REG_AW-1:0] addr, input logic [31:0] data,
         input int bp, output axi_resp_e resp, output bit ok);
      int wait_cnt;
      ok       = 1'b0;
      resp     = OKAY;
      wait_cnt = 0;
      @(posedge sys_clk);
      s_axi_awaddr  <= addr;
      s_axi_awvalid <= 1'b1;
      s_axi_wdata   <= data;
      s_axi_wvalid  <= 1'b1;
      @(negedge sys_clk);
      while (!(s_axi_awready && s_axi_wready) && wait_cnt < HS_LIMIT) begin
         @(negedge sys_clk);
         wait_cnt++;
      end
      @(posedge sys_clk);                     // Accept edge
      s_axi_awvalid <= 1'b0;
      s_axi_wvalid  <= 1'b0;
      if (wait_cnt >= HS_LIMIT) begin
         errors++;
         $display("Write to 0x%02h: no awready within %0d cycles", addr, HS_LIMIT);
         return;
      end
      wait_cnt = 0;
      @(negedge sys_clk);
      while (!s_axi_bvalid && wait_cnt < HS_LIMIT) begin
         @(negedge sys_clk);
         wait_cnt++;
      end
      if (!s_axi_bvalid) begin
         errors++;
         $display("Write to 0x%02h: no bvalid within %0d cycles", addr, HS_LIMIT);
         return;
      end
      resp = s_axi_bresp;
      repeat (bp) begin                       // Response must hold while stalled
         @(negedge sys_clk);
         if (!s_axi_bvalid || s_axi_bresp !== resp) begin
            errors++;
            $display("Write to 0x%02h: bvalid or bresp changed while bready low", addr);
         end
         if (s_axi_awready || s_axi_wready || s_axi_arready) begin
            errors++;
            $display("Write to 0x%02h: a ready output was high while bvalid waited", addr);
         end
      end
      @(posedge sys_clk);
      s_axi_bready <= 1'b1;
      @(posedge sys_clk);                     // bvalid and bready meet here
      s_axi_bready <= 1'b0;
      ok = 1'b1;
   endtask

   task automatic read_bus(input logic [REG_AW-1:0] addr, input int bp,
         output logic [31:0] data, output axi_resp_e resp, output bit ok);
      int wait_cnt;
      ok       = 1'b0;
      data     = '0;
      resp     = OKAY;
      wait_cnt = 0;
      @(posedge sys_clk);
      s_axi_araddr  <= addr;
      s_axi_arvalid <= 1'b1;
      @(negedge sys_clk);
      while (!s_axi_arready && wait_cnt < HS_LIMIT) begin
         @(negedge sys_clk);
         wait_cnt++;
      end
      @(posedge sys_clk);                     // Accept edge
      s_axi_arvalid <= 1'b0;
      if (wait_cnt >= HS_LIMIT) begin
         errors++;
         $display("Read of 0x%02h: no arready within %0d cycles", addr, HS_LIMIT);
         return;
      end
      wait_cnt = 0;
      @(negedge sys_clk);
      while (!s_axi_rvalid && wait_cnt < HS_LIMIT) begin
         @(negedge sys_clk);
         wait_cnt++;
      end
      if (!s_axi_rvalid) begin
         errors++;
         $display("Read of 0x%02h: no rvalid within %0d cycles", addr, HS_LIMIT);
         return;
      end
      data = s_axi_rdata;
      resp = s_axi_rresp;
      repeat (bp) begin
         @(negedge sys_clk);
         if (!s_axi_rvalid || s_axi_rdata !== data || s_axi_rresp !== resp) begin
            errors++;
            $display("Read of 0x%02h: rvalid, rdata or rresp changed while rready low", addr);
         end
         if (s_axi_awready || s_axi_wready || s_axi_arready) begin
            errors++;
            $display("Read of 0x%02h: a ready output was high while rvalid waited", addr);
         end
      end
      @(posedge sys_clk);
      s_axi_rready <= 1'b1;
      @(posedge sys_clk);                     // rvalid and rready meet here
      s_axi_rready <= 1'b0;
      ok = 1'b1;
   endtask

   //####################################################################
   // Main sequence
   //####################################################################

   initial begin
      entry_t      e;
      logic [31:0] rnd0, rnd1, rdata;
      axi_resp_e   resp;
      bit          ok;
      void'($urandom(48992));                 // One seed for the run
      rnd0 = $urandom();
      rnd1 = $urandom();
      build_table(rnd0, rnd1);
      table_ready = 1'b1;
      rst_n         <= 1'b0;
      gpio_in       <= '0;
      s_axi_awaddr  <= '0;
      s_axi_awvalid <= 1'b0;
      s_axi_wdata   <= '0;
      s_axi_wvalid  <= 1'b0;
      s_axi_bready  <= 1'b0;
      s_axi_araddr  <= '0;
      s_axi_arvalid <= 1'b0;
      s_axi_rready  <= 1'b0;
      repeat (10) @(posedge sys_clk);
      rst_n <= 1'b1;
      for (int i = 0; i < tbl.size(); i++) begin
         e = tbl[i];
         case (e.op)
            OP_WR: begin
               write_bus(e.addr, e.wdata, e.bp, resp, ok);
               if (ok && resp !== e.exp_resp) begin
                  errors++;
                  $display("[ERROR] %s bresp: expected %0h, actual %0h", e.name, e.exp_resp, resp);
               end
            end
            OP_RD: begin
               read_bus(e.addr, e.bp, rdata, resp, ok);
               if (ok && rdata !== e.exp_rdata) begin
                  errors++;
                  $display("[ERROR] %s rdata: expected %08h, actual %08h",
                           e.name, e.exp_rdata, rdata);
               end
               if (ok && resp !== e.exp_resp) begin
                  errors++;
                  $display("[ERROR] %s rresp: expected %0h, actual %0h", e.name, e.exp_resp, resp);
               end
            end
            default: begin
               @(posedge sys_clk);
               gpio_in <= e.pin;
               repeat (4) @(posedge sys_clk);  // Margin over sync and latch delay
            end
         endcase
         @(negedge sys_clk);                  // Pin outputs settled here
         if (gpio_out !== e.exp_out) begin
            errors++;
            $display("[ERROR] %s gpio_out: expected %06h, actual %06h",
                     e.name, e.exp_out, gpio_out);
         end
         if (gpio_oe !== e.exp_oe) begin
            errors++;
            $display("[ERROR] %s gpio_oe: expected %06h, actual %06h", e.name, e.exp_oe, gpio_oe);
         end
         if (gpio_irq !== e.exp_irq) begin
            errors++;
            $display("[ERROR] %s gpio_irq: expected %0b, actual %0b", e.name, e.exp_irq, gpio_irq);
         end
      end
      $display("Summary: %0d entries run, %0d errors", tbl.size(), errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // Run length bound from the table size
   initial begin
      wait (table_ready);
      repeat (tbl.size() * 40 + 100) @(posedge sys_clk);
      $display("Watchdog expired after %0d cycles, run did not finish", tbl.size() * 40 + 100);
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: verilog.f
rtl/gpio_axi_pkg.sv
rtl/gpio_reg_pkg.sv
rtl/gpio_axi_slave.sv
rtl/gpio_regs.sv
rtl/gpio_pin_sync.sv
rtl/gpio_top.sv
sim/tb_clock_gen.sv
sim/tb_gpio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the GPIO testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f verilog.f --top-module tb_gpio -o sim_gpio \
   && ./obj_dir/sim_gpio 2>&1 | tee sim.log \
   || { echo "Build or run step failed"; exit 1; }

grep -q "Simulation completed successfully" sim.log \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
